/* hdl/encoderCfg.svh */
`ifndef ENCODER_CFG_SVH
`define ENCODER_CFG_SVH

////////////////////
// Frame geometry
////////////////////

`define ENC_FRAME_LEN 80 // Samples per frame
`define ENC_SUBFRAME_LEN 40 // Samples per subframe
`define ENC_FRAMES_PER_ANALYSIS 2 // Buffered frames per analysis window

////////////////////
// Sequencer sizing
////////////////////

`define ENC_UNIT_COUNT 15 // Processing units behind the math mux

// Frame chain occupies steps 0 to 18, subframe chain follows at 19
`define ENC_FRAME_STEPS 19
`define ENC_SUBFRAME_STEPS 9

`endif

/* hdl/encoderPkg.sv */
`include "encoderCfg.svh"

package encoderPkg;

	////////////////////
	// Plain vectors
	////////////////////

	typedef logic [5:0] muxSel_t; // Step number, doubles as math mux select
	typedef logic [`ENC_UNIT_COUNT-1:0] unitMask_t; // One bit per unit
	typedef logic [15:0] sampleIndex_t; // Subframe sample offset

	// Value of each id is its bit position in unitMask_t
	typedef enum logic [3:0]
	{
		autocorr,
		lagWindow,
		levinson,
		azToLsp,
		quaLsp,
		intLpc,
		intQlpc,
		math1,
		percVar,
		weightAz,
		residu,
		synFilt,
		pitchOl,
		math2,
		math3
	} unitId_t;

	////////////////////
	// State machines
	////////////////////

	typedef enum logic [2:0]
	{
		execIdle,
		execAwaitAnalysis,
		execIssue,
		execAwaitDone,
		execLoopCheck,
		execFinish
	} execState_t;

	typedef enum logic
	{
		gateIdle,
		gateCounting
	} gateState_t;

	typedef struct packed
	{
		unitId_t unit; // Unit run by this step
		logic lastFrameStep; // End of the frame chain
		logic lastSubframeStep; // End of one subframe pass
	} stepCmd_t;

	typedef struct packed
	{
		unitMask_t unitStart; // One-hot start, one cycle wide
		muxSel_t muxSel;
	} unitIssue_t;

endpackage

/* hdl/frameGate.sv */
`timescale 1ns/10ps
`include "encoderCfg.svh"

module frameGate
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	output logic analysisReady
);
	import encoderPkg::*;

	gateState_t state;
	logic [1:0] frameCount; // Frames seen in the current window
	logic windowFull;

	assign windowFull = (frameCount == 2'(`ENC_FRAMES_PER_ANALYSIS));

	// One-cycle pulse while the full count is held
	assign analysisReady = (state == gateCounting) && windowFull;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= gateIdle;
			frameCount <= '0;
		end
		else
		begin
			case (state)
				gateIdle:
				begin
					if (start)
						state <= gateCounting; // Counting begins next cycle
				end
				gateCounting:
				begin
					// A frame landing on the clear cycle opens the next window
					if (windowFull)
						frameCount <= frameDone ? 2'd1 : 2'd0;
					else if (frameDone)
						frameCount <= frameCount + 2'd1;
				end
				default:
					state <= gateIdle;
			endcase
		end
	end

endmodule

/* hdl/stepDecode.sv */
`timescale 1ns/10ps
`include "encoderCfg.svh"

module stepDecode
(
	input encoderPkg::muxSel_t step,
	output encoderPkg::stepCmd_t cmd
);
	import encoderPkg::*;

	unitId_t unit;

	////////////////////
	// Step table
	////////////////////

	always_comb
	begin
		case (step)
			6'd0: unit = autocorr;
			6'd1: unit = lagWindow;
			6'd2: unit = levinson;
			6'd3: unit = azToLsp;
			6'd4: unit = quaLsp;
			6'd5: unit = intLpc; // Unquantized interpolation
			6'd6: unit = intQlpc; // Quantized interpolation
			6'd7: unit = math1;
			6'd8: unit = percVar;
			6'd9: unit = weightAz;
			6'd10: unit = weightAz;
			6'd11: unit = residu;
			6'd12: unit = synFilt;
			6'd13: unit = weightAz; // Second half of the frame
			6'd14: unit = weightAz;
			6'd15: unit = residu;
			6'd16: unit = synFilt;
			6'd17: unit = pitchOl;
			6'd18: unit = math2;
			6'd19: unit = weightAz; // Subframe chain starts here
			6'd20: unit = weightAz;
			6'd21: unit = math3;
			6'd22: unit = synFilt;
			6'd23: unit = synFilt;
			6'd24: unit = residu;
			6'd25: unit = synFilt;
			6'd26: unit = residu;
			6'd27: unit = synFilt;
			default: unit = autocorr;
		endcase
	end

	// Phase ends hand control to the loop check
	always_comb
	begin
		cmd.unit = unit;
		cmd.lastFrameStep = (step == muxSel_t'(`ENC_FRAME_STEPS - 1));
		cmd.lastSubframeStep =
			(step == muxSel_t'(`ENC_FRAME_STEPS + `ENC_SUBFRAME_STEPS - 1));
	end

endmodule

/* hdl/stepExecute.sv */
`timescale 1ns/10ps
`include "encoderCfg.svh"

module stepExecute
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic analysisReady,
	input encoderPkg::unitMask_t unitDone,
	input logic moreSubframes,
	output encoderPkg::muxSel_t step,
	input encoderPkg::stepCmd_t cmd,
	output encoderPkg::unitIssue_t issue,
	output logic frameBegin,
	output logic subframeAdvance,
	output logic frameFinish
);
	import encoderPkg::*;

	execState_t state;
	unitMask_t unitBit; // One-hot of the decoded unit
	logic unitFinished;
	logic phaseEnd;

	assign unitBit = unitMask_t'(1) << cmd.unit;

	// Only the running unit's done counts
	assign unitFinished = (state == execAwaitDone) && (|(unitDone & unitBit));
	assign phaseEnd = cmd.lastFrameStep | cmd.lastSubframeStep;

	////////////////////
	// Outputs
	////////////////////

	assign issue = '{
		unitStart: (state == execIssue) ? unitBit : '0,
		muxSel: step // Step register holds until the next issue
	};

	assign frameBegin = (state == execIssue) && (step == '0);
	assign subframeAdvance = unitFinished && cmd.lastSubframeStep;
	assign frameFinish = (state == execFinish);

	////////////////////
	// Issue and wait FSM
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= execIdle;
			step <= '0;
		end
		else if (divErr)
			state <= execIdle; // Abort the frame
		else
		begin
			case (state)
				execIdle:
				begin
					if (start)
						state <= execAwaitAnalysis;
				end
				execAwaitAnalysis:
				begin
					if (analysisReady)
					begin
						state <= execIssue;
						step <= '0; // Autocorrelation first
					end
				end
				execIssue:
					state <= execAwaitDone;
				execAwaitDone:
				begin
					if (unitFinished)
					begin
						if (phaseEnd)
							state <= execLoopCheck;
						else
						begin
							state <= execIssue;
							step <= step + 6'd1;
						end
					end
				end
				execLoopCheck:
				begin
					// Index was advanced at the edge that entered this state
					if (moreSubframes)
					begin
						state <= execIssue;
						step <= muxSel_t'(`ENC_FRAME_STEPS);
					end
					else
						state <= execFinish;
				end
				execFinish:
					state <= execIdle;
				default:
					state <= execIdle;
			endcase
		end
	end

endmodule

/* hdl/subframeResult.sv */
`timescale 1ns/10ps
`include "encoderCfg.svh"

module subframeResult
(
	input logic clock,
	input logic reset,
	input logic frameBegin,
	input logic subframeAdvance,
	input logic frameFinish,
	output logic moreSubframes,
	output logic encodeDone
);
	import encoderPkg::*;

	sampleIndex_t subframeIndex; // First sample of the current subframe

	// Loop runs while a full subframe is left in the frame
	assign moreSubframes = (subframeIndex < sampleIndex_t'(`ENC_FRAME_LEN));

	always_ff @(posedge clock)
	begin
		if (reset)
			subframeIndex <= '0;
		else if (frameBegin)
			subframeIndex <= '0;
		else if (subframeAdvance)
			subframeIndex <= subframeIndex + sampleIndex_t'(`ENC_SUBFRAME_LEN);
	end

	// Frame complete, one cycle after the finish state
	always_ff @(posedge clock)
	begin
		if (reset)
			encodeDone <= 1'b0;
		else
			encodeDone <= frameFinish;
	end

endmodule

/* hdl/encoderSequencer.sv */
`timescale 1ns/10ps

module encoderSequencer
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic frameDone,
	input encoderPkg::unitMask_t unitDone,
	output encoderPkg::unitIssue_t issue,
	output logic encodeDone
);
	import encoderPkg::*;

	logic analysisReady;
	muxSel_t step;
	stepCmd_t cmd;
	logic frameBegin;
	logic subframeAdvance;
	logic frameFinish;
	logic moreSubframes;

	frameGate gate
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.analysisReady(analysisReady)
	);

	stepDecode decode
	(
		.step(step),
		.cmd(cmd)
	);

	stepExecute execute
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.analysisReady(analysisReady),
		.unitDone(unitDone),
		.moreSubframes(moreSubframes),
		.step(step),
		.cmd(cmd),
		.issue(issue),
		.frameBegin(frameBegin),
		.subframeAdvance(subframeAdvance),
		.frameFinish(frameFinish)
	);

	subframeResult result
	(
		.clock(clock),
		.reset(reset),
		.frameBegin(frameBegin),
		.subframeAdvance(subframeAdvance),
		.frameFinish(frameFinish),
		.moreSubframes(moreSubframes),
		.encodeDone(encodeDone)
	);

endmodule

/* bench/encoderSequencerBench.sv */
`timescale 1ns/10ps
`include "encoderCfg.svh"

module encoderSequencerBench;
	import encoderPkg::*;

	localparam int frameSteps = `ENC_FRAME_STEPS + 2 * `ENC_SUBFRAME_STEPS; // Starts per frame
	localparam int waitLimit = 3000; // Cycles

	logic clock;
	logic reset;
	logic start;
	logic divErr;
	logic frameDone;
	unitMask_t unitDone;
	unitIssue_t issue;
	logic encodeDone;

	unitId_t expectedUnits [frameSteps]; // Unit order of one frame
	logic [31:0] mainRng;
	logic [31:0] stimRng;
	int frameRequests; // Written by the main flow
	int framesHandled;
	int framesCompleted;
	int cycle;
	int pos; // Starts seen in the current frame
	int doneCycle;
	int frameCount; // frameDone pulses since the gate armed
	int lastFrameCycle;
	int startEvents;
	int startsServed;
	int respDelay;
	int frameGap;
	int abortAt;
	int abortDelay;
	logic inFrame;
	logic outstanding; // Started unit has not answered yet
	logic respBusy;
	logic framesOn;
	unitMask_t curMask;
	unitMask_t respMask;

	encoderSequencer UUT
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.frameDone(frameDone),
		.unitDone(unitDone),
		.issue(issue),
		.encodeDone(encodeDone)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
				expected);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	////////////////////
	// Reference model
	////////////////////

	task automatic buildModel();
		unitId_t frameChain [`ENC_FRAME_STEPS];
		unitId_t subframeChain [`ENC_SUBFRAME_STEPS];
		int i;
		int p;
		frameChain = '{autocorr, lagWindow, levinson, azToLsp, quaLsp, intLpc, intQlpc, math1,
			percVar, weightAz, weightAz, residu, synFilt, weightAz, weightAz, residu, synFilt,
			pitchOl, math2};
		subframeChain = '{weightAz, weightAz, math3, synFilt, synFilt, residu, synFilt, residu,
			synFilt};
		for (i = 0; i < `ENC_FRAME_STEPS; i++)
			expectedUnits[i] = frameChain[i];
		for (p = 0; p < 2; p++) // Two subframes per frame
			for (i = 0; i < `ENC_SUBFRAME_STEPS; i++)
				expectedUnits[`ENC_FRAME_STEPS + p * `ENC_SUBFRAME_STEPS + i] = subframeChain[i];
	endtask

	////////////////////
	// Monitor
	////////////////////

	task automatic observeCycle();
		int expStep;
		if (frameRequests != framesHandled)
		begin
			framesHandled = frameRequests;
			inFrame = 1'b1;
			pos = 0;
			outstanding = 1'b0;
		end
		if (outstanding && ((unitDone & curMask) != '0)) // Strays from other units ignored
		begin
			outstanding = 1'b0;
			doneCycle = cycle;
		end
		if (issue.unitStart != '0)
		begin
			checkValue(32'(inFrame), 1, "unit start outside an active frame");
			checkValue(32'(outstanding), 0, "unit start while the previous unit is busy");
			checkValue(32'(pos < frameSteps), 1, "start count within one frame");
			checkValue(32'($countones(issue.unitStart)), 1, "one-hot unitStart");
			checkValue(32'(issue.unitStart), 32'(unitMask_t'(1) << expectedUnits[pos]),
				"started unit");
			expStep = (pos < 28) ? pos : pos - `ENC_SUBFRAME_STEPS; // Second pass reuses steps
			checkValue(32'(issue.muxSel), 32'(expStep), "muxSel at start");
			if (pos == 0)
			begin
				checkValue(32'(frameCount >= 2 && frameCount % 2 == 0), 1,
					"even frameDone count at autocorr start");
				checkValue(32'(cycle - lastFrameCycle), 2, "cycles from frameDone to autocorr");
			end
			else if (pos == 19 || pos == 28)
				checkValue(32'(cycle - doneCycle), 2, "cycles from phase end to next start");
			else
				checkValue(32'(cycle - doneCycle), 1, "cycles from done to next start");
			curMask = issue.unitStart;
			outstanding = 1'b1;
			pos = pos + 1;
			startEvents = startEvents + 1;
		end
		if (frameDone)
		begin
			frameCount = frameCount + 1;
			lastFrameCycle = cycle;
		end
		if (encodeDone)
		begin
			checkValue(32'(inFrame), 1, "encodeDone outside an active frame");
			checkValue(32'(pos), frameSteps, "starts before encodeDone");
			checkValue(32'(cycle - doneCycle), 3, "cycles from last done to encodeDone");
			inFrame = 1'b0;
			framesCompleted = framesCompleted + 1;
		end
		if (divErr)
		begin
			inFrame = 1'b0; // Frame aborted
			outstanding = 1'b0;
		end
	endtask

	initial
	begin
		cycle = 0;
		pos = 0;
		doneCycle = 0;
		frameCount = 0;
		lastFrameCycle = -100;
		startEvents = 0;
		framesHandled = 0;
		framesCompleted = 0;
		inFrame = 1'b0;
		outstanding = 1'b0;
		curMask = '0;
		forever
		begin
			@(negedge clock);
			cycle = cycle + 1;
			if (!reset)
				observeCycle();
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic driveCycle();
		unitMask_t strayMask;
		unitMask_t doneMask;
		frameDone <= 1'b0;
		if (framesOn)
		begin
			if (frameGap == 0)
			begin
				frameDone <= 1'b1;
				stimRng = lcgNext(stimRng);
				frameGap = 1 + int'(stimRng[19:16]);
			end
			else
				frameGap = frameGap - 1;
		end
		if (divErr)
		begin
			respBusy = 1'b0; // Aborted unit never answers
			startsServed = startEvents;
		end
		else if (startsServed != startEvents)
		begin
			startsServed = startEvents;
			respMask = curMask;
			respBusy = 1'b1;
			stimRng = lcgNext(stimRng);
			respDelay = 1 + int'(stimRng[18:16]); // 1 to 8 cycles
		end
		doneMask = '0;
		if (respBusy)
		begin
			respDelay = respDelay - 1;
			if (respDelay == 0)
			begin
				doneMask = respMask;
				respBusy = 1'b0;
			end
		end
		stimRng = lcgNext(stimRng);
		strayMask = '0;
		if (stimRng[29:28] == 2'd0)
			strayMask = stimRng[30:16] & ~(respBusy ? respMask : '0);
		unitDone <= strayMask | doneMask;
	endtask

	initial
	begin
		frameDone = 1'b0;
		unitDone = '0;
		stimRng = 32'hb151;
		frameGap = 3;
		respBusy = 1'b0;
		respMask = '0;
		respDelay = 0;
		startsServed = 0;
		forever
		begin
			@(posedge clock);
			driveCycle();
		end
	end

	////////////////////
	// Main flow
	////////////////////

	task automatic requestFrame();
		@(posedge clock);
		start <= 1'b1;
		frameRequests = frameRequests + 1;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic awaitFrames(input int target);
		int waited;
		waited = 0;
		while (framesCompleted < target)
		begin
			@(posedge clock);
			waited = waited + 1;
			if (waited > waitLimit)
				reportTimeout("encodeDone of the current frame");
		end
	endtask

	task automatic awaitStarts(input int target);
		int waited;
		waited = 0;
		while (pos < target)
		begin
			@(posedge clock);
			waited = waited + 1;
			if (waited > waitLimit)
				reportTimeout("unit starts before the abort point");
		end
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		divErr = 1'b0;
		framesOn = 1'b0;
		frameRequests = 0;
		mainRng = 32'hb151;
		buildModel();
		mainRng = lcgNext(mainRng);
		abortAt = 3 + int'(mainRng[19:16]); // Well inside the frame chain
		mainRng = lcgNext(mainRng);
		abortDelay = int'(mainRng[18:16]);
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		repeat (20)
		begin
			@(negedge clock);
			checkValue(32'(issue.unitStart), 0, "unitStart after reset");
			checkValue(32'(issue.muxSel), 0, "muxSel after reset");
			checkValue(32'(encodeDone), 0, "encodeDone after reset");
		end
		requestFrame();
		framesOn <= 1'b1; // Gate armed at this edge
		awaitFrames(1);
		requestFrame();
		awaitFrames(2);
		requestFrame();
		awaitStarts(abortAt);
		repeat (abortDelay) @(posedge clock);
		divErr <= 1'b1;
		@(posedge clock);
		divErr <= 1'b0;
		repeat (60) @(posedge clock); // Any start here is flagged
		requestFrame();
		awaitFrames(3);
		$display("Regression passed");
		$finish;
	end

endmodule

/* encoderSequencer.f */
+incdir+hdl
hdl/encoderPkg.sv
hdl/frameGate.sv
hdl/stepDecode.sv
hdl/stepExecute.sv
hdl/subframeResult.sv
hdl/encoderSequencer.sv
bench/encoderSequencerBench.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module encoderSequencerBench \
	-f encoderSequencer.f -o encoderSim &&
	./obj_dir/encoderSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log && echo "Run passed" ||
	{ echo "Run failed"; exit 1; }
